// File: hw/cpc_ram_pkg.sv
// Shared types and constants for the 512K RAM expansion bank logic
// Referenced by scoped name from every RTL module of the expansion
package cpc_ram_pkg;

  // 64K bank number ccc from the select byte
  typedef logic [2:0] bank_t;

  // Block switching scheme bbb from the select byte
  typedef logic [2:0] scheme_t;

  // Processor 16K block, {adr15, adr14}
  typedef logic [1:0] block_t;

  // SRAM address bits 18..14 as {bank, block}
  typedef logic [4:0] ram_adr_hi_t;

  // Data bits 7..6 of a bank-select write
  localparam logic [1:0] SELECT_CODE = 2'b11;

  // Schemes tested by both mapper and overdrive
  localparam scheme_t SCHEME_TOP    = 3'b001; // Top block from expansion
  localparam scheme_t SCHEME_FULL   = 3'b010; // Whole 64K from expansion
  localparam scheme_t SCHEME_SCREEN = 3'b011; // Block 01 redirected onto screen block

  // Blocks with special meaning in the mapping table
  localparam block_t BLOCK_TOP = 2'b11; // &C000..&FFFF
  localparam block_t BLOCK_ONE = 2'b01; // &4000..&7FFF

endpackage

// File: hw/bank_select_reg.sv
// Bank and scheme register of the RAM expansion
// Loaded by a Z80 I/O write of 11cccbbb with adr15 low, sampled on clk
`timescale 1ns/1ps

module bank_select_reg (
  input  logic                clk,
  input  logic                reset_b,
  input  logic                iorq_b,
  input  logic                wr_b,
  input  logic                adr15,
  input  logic [7:0]          data,
  output cpc_ram_pkg::bank_t   bank,
  output cpc_ram_pkg::scheme_t scheme
);

  logic select_wr; // Bank-select I/O write seen at this edge

  // I/O write, port decode on adr15 only, marker in the top two data bits
  assign select_wr = !iorq_b && !wr_b && !adr15 &&
                     (data[7:6] == cpc_ram_pkg::SELECT_CODE);

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      bank   <= '0;               // Bank 0
      scheme <= '0;               // Scheme 000, internal RAM mapping
    end else if (select_wr) begin
      bank   <= data[5:3];        // ccc
      scheme <= data[2:0];        // bbb
    end
    // Other I/O and memory cycles keep the current mapping
  end

endmodule

// File: hw/bus_cycle_tracker.sv
// Memory cycle tracker for the Z80 bus
// Registers mreq_b, flags the first edge of a memory cycle and the edges after it,
// and latches the accessed 16K block so all other logic sees one stable view
`timescale 1ns/1ps

module bus_cycle_tracker (
  input  logic                clk,
  input  logic                reset_b,
  input  logic                mreq_b,
  input  logic                adr15,
  input  logic                adr14,
  output logic                cycle_start,
  output logic                cycle_active,
  output cpc_ram_pkg::block_t block
);

  logic mreq_b_q; // mreq_b at the previous edge

  // Strobe low now, high at the previous edge
  assign cycle_start  = !mreq_b && mreq_b_q;

  // Strobe low now and at the previous edge
  assign cycle_active = !mreq_b && !mreq_b_q;

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      mreq_b_q <= 1'b1;           // Bus idle
      block    <= '0;
    end else begin
      mreq_b_q <= mreq_b;
      if (cycle_start) begin
        block <= {adr15, adr14};  // Held until the next cycle start
      end
    end
  end

endmodule

// File: hw/block_mapper.sv
// Mapping table of the 512K expansion
// Turns bank, scheme and the latched block into the expansion select and
// the high SRAM address bits. On a 464 the shadow bank stands in for the
// internal RAM, and the bank that aliases onto it is folded one bank lower.
// Chip select is only asserted inside an active memory cycle.
`timescale 1ns/1ps

module block_mapper #(
  parameter bit MODE_464  = 1'b1, // 464 only with the shadow bank in place of internal RAM
  parameter bit SHADOW_HI = 1'b0  // Shadow bank 111 when set and 011 when clear
) (
  input  cpc_ram_pkg::bank_t      bank,
  input  cpc_ram_pkg::scheme_t    scheme,
  input  cpc_ram_pkg::block_t     block,
  input  logic                    cycle_active,
  output logic                    ram_sel,
  output logic                    ramcs_b,
  output cpc_ram_pkg::ram_adr_hi_t ram_adr_hi
);

  localparam cpc_ram_pkg::bank_t SHADOW_BANK = {SHADOW_HI, 2'b11};

  cpc_ram_pkg::bank_t eff_bank; // Bank after shadow aliasing
  logic               blk_or;   // adr15 OR adr14 of the latched block

  // On a 464 requests for the reserved shadow bank fall to the even bank below
  assign eff_bank = (MODE_464 && (bank == SHADOW_BANK)) ? (SHADOW_BANK & 3'b110) : bank;

  assign blk_or = block[1] | block[0];

  always_comb begin
    ram_sel    = MODE_464;              // Internal RAM lives in the shadow bank on a 464
    ram_adr_hi = {SHADOW_BANK, block};  // Default is the internal result
    case (scheme)
      cpc_ram_pkg::SCHEME_TOP: begin
        if (block == cpc_ram_pkg::BLOCK_TOP) begin
          ram_sel    = 1'b1;
          ram_adr_hi = {eff_bank, 2'b11};
        end
      end
      cpc_ram_pkg::SCHEME_FULL: begin   // All four blocks from the bank
        ram_sel    = 1'b1;
        ram_adr_hi = {eff_bank, block};
      end
      cpc_ram_pkg::SCHEME_SCREEN: begin
        if (block == cpc_ram_pkg::BLOCK_TOP) begin
          ram_sel    = 1'b1;
          ram_adr_hi = {eff_bank, 2'b11};
        end else begin
          // Block 01 lands on the shadow screen block 11
          ram_adr_hi = {SHADOW_BANK, blk_or, block[0]};
        end
      end
      default: begin
        // Schemes 1xx page one block of the bank into &4000 and 000 stays internal
        if (scheme[2] && (block == cpc_ram_pkg::BLOCK_ONE)) begin
          ram_sel    = 1'b1;
          ram_adr_hi = {eff_bank, scheme[1:0]};
        end
      end
    endcase
  end

  // Low only during the active part of a memory cycle
  assign ramcs_b = !(ram_sel && cycle_active);

endmodule

// File: hw/overdrive_ctrl.sv
// Overdrive flags for adr15 and adr14
// The board uses them to force the processor address seen by internal RAM,
// so redirected blocks do not write into the screen area
`timescale 1ns/1ps

module overdrive_ctrl #(
  parameter bit OVERDRIVE = 1'b1 // Forcing logic present
) (
  input  logic                 clk,
  input  logic                 reset_b,
  input  logic                 mreq_b,
  input  logic                 cycle_active,
  input  cpc_ram_pkg::scheme_t scheme,
  input  cpc_ram_pkg::block_t  block,
  output logic                 overdrive_hi,
  output logic                 overdrive_lo
);

  logic cycle_active_q; // cycle_active at the previous edge
  logic arm;            // First edge of the active part of a cycle
  logic hi_req;
  logic lo_req;

  assign arm = cycle_active && !cycle_active_q;

  // Block 01 pushed up to &C000 in the screen scheme
  assign hi_req = (scheme == cpc_ram_pkg::SCHEME_SCREEN) &&
                  (block == cpc_ram_pkg::BLOCK_ONE);

  // Block 11 pushed down to &0000 when it comes from the expansion
  assign lo_req = ((scheme == cpc_ram_pkg::SCHEME_TOP) ||
                   (scheme == cpc_ram_pkg::SCHEME_FULL)) &&
                  (block == cpc_ram_pkg::BLOCK_TOP);

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      cycle_active_q <= 1'b0;
      overdrive_hi   <= 1'b0;
      overdrive_lo   <= 1'b0;
    end else begin
      cycle_active_q <= cycle_active;
      if (mreq_b) begin           // Strobe gone, release the bus
        overdrive_hi <= 1'b0;
        overdrive_lo <= 1'b0;
      end else if (arm) begin
        overdrive_hi <= OVERDRIVE && hi_req;
        overdrive_lo <= OVERDRIVE && lo_req;
      end
    end
  end

endmodule

// File: hw/ram512k_top.sv
// Top level of the 512K RAM expansion bank logic
// Connects the Z80 bus to the bank register, the cycle tracker, the mapper
// and the overdrive flags, and drives the SRAM control pins
`timescale 1ns/1ps

module ram512k_top #(
  parameter bit MODE_464  = 1'b1, // 464 with shadow bank
  parameter bit SHADOW_HI = 1'b0, // Shadow bank 111 instead of 011
  parameter bit OVERDRIVE = 1'b1  // Address forcing enabled
) (
  input  logic                    clk,
  input  logic                    reset_b,
  input  logic                    adr15,
  input  logic                    adr14,
  input  logic                    iorq_b,
  input  logic                    mreq_b,
  input  logic                    ramrd_b,
  input  logic                    wr_b,
  input  logic [7:0]              data,
  output logic                    ramdis,
  output logic                    ramcs_b,
  output cpc_ram_pkg::ram_adr_hi_t ramadrhi,
  output logic                    ramoe_b,
  output logic                    ramwe_b,
  output logic                    overdrive_hi,
  output logic                    overdrive_lo
);

  cpc_ram_pkg::bank_t   bank;
  cpc_ram_pkg::scheme_t scheme;
  cpc_ram_pkg::block_t  block;
  logic                 cycle_active;

  assign ramoe_b = ramrd_b; // SRAM output enable straight from the bus
  assign ramwe_b = wr_b;

  bank_select_reg u_bank_select_reg (
    .clk     (clk),
    .reset_b (reset_b),
    .iorq_b  (iorq_b),
    .wr_b    (wr_b),
    .adr15   (adr15),
    .data    (data),
    .bank    (bank),
    .scheme  (scheme)
  );

  bus_cycle_tracker u_bus_cycle_tracker (
    .clk          (clk),
    .reset_b      (reset_b),
    .mreq_b       (mreq_b),
    .adr15        (adr15),
    .adr14        (adr14),
    .cycle_start  (),
    .cycle_active (cycle_active),
    .block        (block)
  );

  block_mapper #(
    .MODE_464  (MODE_464),
    .SHADOW_HI (SHADOW_HI)
  ) u_block_mapper (
    .bank         (bank),
    .scheme       (scheme),
    .block        (block),
    .cycle_active (cycle_active),
    .ram_sel      (ramdis),       // High disables internal RAM
    .ramcs_b      (ramcs_b),
    .ram_adr_hi   (ramadrhi)
  );

  overdrive_ctrl #(
    .OVERDRIVE (OVERDRIVE)
  ) u_overdrive_ctrl (
    .clk          (clk),
    .reset_b      (reset_b),
    .mreq_b       (mreq_b),
    .cycle_active (cycle_active),
    .scheme       (scheme),
    .block        (block),
    .overdrive_hi (overdrive_hi),
    .overdrive_lo (overdrive_lo)
  );

endmodule

// File: verif/ram512k_asserts.sv
// Concurrent checks on the SRAM chip select and the overdrive flags
// Bound into every ram512k_top instance by the bind statement below
`timescale 1ns/1ps

module ram512k_asserts (
  input logic clk,
  input logic reset_b,
  input logic mreq_b,
  input logic ramcs_b,
  input logic overdrive_hi,
  input logic overdrive_lo
);

  // No SRAM access outside a memory cycle
  cs_idle: assert property (@(posedge clk) disable iff (!reset_b) mreq_b |-> ramcs_b)
    else $error("ramcs_b low while mreq_b is high");

  // Forcing both address lines at once would corrupt the bus
  od_excl: assert property (@(posedge clk) disable iff (!reset_b)
                            !(overdrive_hi && overdrive_lo))
    else $error("overdrive_hi and overdrive_lo high together");

  // Flags released on the first edge that sees the strobe high
  od_release: assert property (@(posedge clk) disable iff (!reset_b)
                               mreq_b |=> !(overdrive_hi || overdrive_lo))
    else $error("overdrive flag still high after the strobe ended");

endmodule

bind ram512k_top ram512k_asserts u_asserts (
  .clk          (clk),
  .reset_b      (reset_b),
  .mreq_b       (mreq_b),
  .ramcs_b      (ramcs_b),
  .overdrive_hi (overdrive_hi),
  .overdrive_lo (overdrive_lo)
);

// File: verif/ram512k_tb.sv
// Testbench for the 512K RAM expansion bank logic
// Drives Z80 I/O and memory cycles on the falling clock edge and checks the SRAM
// select, high address bits and overdrive flags against a reference mapping
`timescale 1ns/1ps

module ram512k_tb;

  localparam bit MODE_464  = 1'b1; // Same as the DUT defaults
  localparam bit SHADOW_HI = 1'b0;
  localparam bit OVERDRIVE = 1'b1;
  localparam int NUM_RANDOM     = 200;
  localparam int PLANNED_OPS    = 62 + NUM_RANDOM;      // Directed cycles plus random ones
  localparam int PLANNED_CYCLES = 16 + 5 * PLANNED_OPS; // At most five clocks per bus cycle
  localparam int WATCHDOG_NS    = PLANNED_CYCLES * 10 + 1000;

  logic clk = 1'b0;
  logic reset_b, adr15, adr14, iorq_b, mreq_b, ramrd_b, wr_b;
  logic [7:0] data;
  logic ramdis, ramcs_b, ramoe_b, ramwe_b, overdrive_hi, overdrive_lo;
  cpc_ram_pkg::ram_adr_hi_t ramadrhi;

  cpc_ram_pkg::bank_t   model_bank;   // Mapping the DUT should hold
  cpc_ram_pkg::scheme_t model_scheme;
  cpc_ram_pkg::block_t  model_block;  // Block of the current memory cycle
  logic [15:0]          lfsr_state;
  int                   error_count;
  int                   low_edges;    // Edges with mreq_b low in this cycle

  always #5 clk = ~clk; // 10 ns bus clock

  ram512k_top dut (
    .clk (clk), .reset_b (reset_b), .adr15 (adr15), .adr14 (adr14),
    .iorq_b (iorq_b), .mreq_b (mreq_b), .ramrd_b (ramrd_b), .wr_b (wr_b), .data (data),
    .ramdis (ramdis), .ramcs_b (ramcs_b), .ramadrhi (ramadrhi), .ramoe_b (ramoe_b),
    .ramwe_b (ramwe_b), .overdrive_hi (overdrive_hi), .overdrive_lo (overdrive_lo)
  );

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken, bits shifted in from the right
  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[6:0], lfsr_state[0]};
    end
  endtask

  // Expected {select, overdrive_hi, overdrive_lo, address} for one memory cycle
  function automatic logic [7:0] expected_map(input cpc_ram_pkg::bank_t bank,
                                              input cpc_ram_pkg::scheme_t scheme,
                                              input cpc_ram_pkg::block_t blk);
    logic [2:0] shadow;
    logic [2:0] eff;
    logic       sel;
    logic [4:0] adr;
    logic       hi;
    logic       lo;
    shadow = {SHADOW_HI, 2'b11};
    eff    = (MODE_464 && bank == shadow) ? {shadow[2:1], 1'b0} : bank; // Shadow alias
    sel    = MODE_464;                    // Internal result
    adr    = {shadow, blk};
    case (scheme)
      3'b000: ;
      3'b001: if (blk == 2'b11) begin
        sel = 1'b1;
        adr = {eff, 2'b11};
      end
      3'b010: begin
        sel = 1'b1;
        adr = {eff, blk};
      end
      3'b011: if (blk == 2'b11) begin
        sel = 1'b1;
        adr = {eff, 2'b11};
      end else begin
        adr = {shadow, blk[1] | blk[0], blk[0]};
      end
      default: if (blk == 2'b01) begin
        sel = 1'b1;
        adr = {eff, scheme[1:0]};
      end
    endcase
    hi = OVERDRIVE && (scheme == 3'b011) && (blk == 2'b01);
    lo = OVERDRIVE && (scheme == 3'b001 || scheme == 3'b010) && (blk == 2'b11);
    return {sel, hi, lo, adr};
  endfunction

  task automatic check_adr_hi(input string name, input cpc_ram_pkg::ram_adr_hi_t got,
                              input cpc_ram_pkg::ram_adr_hi_t exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Comparing process, samples 2 ns after each rising edge where all outputs are settled
  always @(posedge clk) begin : compare_outputs
    logic [7:0] exp;
    if (!reset_b) begin
      low_edges = 0;
    end else begin
      low_edges = mreq_b ? 0 : low_edges + 1;
      #2;
      exp = expected_map(model_bank, model_scheme, model_block);
      check_bit("ramoe_b", ramoe_b, ramrd_b);
      check_bit("ramwe_b", ramwe_b, wr_b);
      if (low_edges == 0) begin           // Idle or I/O, flags cleared
        check_bit("ramcs_b", ramcs_b, 1'b1);
        check_bit("overdrive_hi", overdrive_hi, 1'b0);
        check_bit("overdrive_lo", overdrive_lo, 1'b0);
      end else begin                      // After E0
        check_bit("ramdis", ramdis, exp[7]);
        check_bit("ramcs_b", ramcs_b, !exp[7]);
        check_adr_hi("ramadrhi", ramadrhi, exp[4:0]);
        check_bit("overdrive_hi", overdrive_hi, (low_edges >= 2) ? exp[6] : 1'b0);
        check_bit("overdrive_lo", overdrive_lo, (low_edges >= 2) ? exp[5] : 1'b0);
      end
    end
  end

  // Memory cycle with the strobe low for three clocks
  task automatic mem_cycle(input cpc_ram_pkg::block_t blk, input logic wr,
                           input logic [7:0] d);
    @(negedge clk);
    {adr15, adr14} = blk;
    model_block    = blk;
    mreq_b  = 1'b0;
    wr_b    = !wr;
    ramrd_b = wr;
    data    = d;
    repeat (3) @(negedge clk);
    mreq_b  = 1'b1;
    wr_b    = 1'b1;
    ramrd_b = 1'b1;
  endtask

  // One-clock I/O cycle, the model follows the bank-select rule
  task automatic io_cycle(input logic wr, input logic a15, input logic [7:0] d);
    @(negedge clk);
    iorq_b = 1'b0;
    wr_b   = !wr;
    adr15  = a15;
    data   = d;
    @(negedge clk);
    iorq_b = 1'b1;
    wr_b   = 1'b1;
    if (wr && !a15 && d[7:6] == 2'b11) begin
      model_bank   = d[5:3];
      model_scheme = d[2:0];
    end
  endtask

  task automatic run_blocks();
    logic [7:0] r;
    for (int b = 0; b < 4; b++) begin
      take_bits(8, r);
      mem_cycle(b[1:0], r[0], r);
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: bus cycles did not finish within the expected time");
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin : stimulus
    logic [7:0] r;
    logic [7:0] d;
    reset_b = 1'b0;
    {adr15, adr14} = 2'b00;
    {iorq_b, mreq_b, ramrd_b, wr_b} = 4'b1111; // Bus idle
    data         = '0;
    model_bank   = '0;
    model_scheme = '0;
    model_block  = '0;
    lfsr_state   = 16'd31717;
    error_count  = 0;
    repeat (16) @(negedge clk);
    reset_b = 1'b1;
    run_blocks();                                      // Reset mapping, scheme 000
    for (int s = 0; s < 8; s++) begin                  // Every scheme, random bank
      take_bits(3, r);
      io_cycle(1'b1, 1'b0, {2'b11, r[2:0], s[2:0]});
      run_blocks();
    end
    io_cycle(1'b1, 1'b0, 8'b11_101_010);               // Known mapping
    take_bits(6, r);
    io_cycle(1'b1, 1'b0, {2'b10, r[5:0]});             // Wrong marker
    io_cycle(1'b1, 1'b1, {2'b11, r[5:0]});             // adr15 high
    mem_cycle(2'b00, 1'b1, {2'b11, r[5:0]});           // Memory write of a select byte
    run_blocks();
    io_cycle(1'b1, 1'b0, 8'b11_011_010);               // Bank 011 folds onto 010
    run_blocks();
    io_cycle(1'b1, 1'b0, 8'b11_010_010);
    run_blocks();
    for (int i = 0; i < NUM_RANDOM; i++) begin
      take_bits(1, r);
      if (r[0]) begin
        take_bits(2, r);
        take_bits(8, d);
        if (r[1]) begin
          io_cycle(1'b1, 1'b0, {2'b11, d[5:0]});       // Valid select write
        end else begin
          io_cycle(d[7], r[0], d);                     // Random I/O cycle
        end
      end else begin
        take_bits(3, r);
        take_bits(8, d);
        mem_cycle(r[1:0], r[2], d);
      end
    end
    repeat (4) @(negedge clk);
    if (error_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "%0d mismatches", error_count);
    end
  end

endmodule

// File: filelist.f
hw/cpc_ram_pkg.sv
hw/bank_select_reg.sv
hw/bus_cycle_tracker.sv
hw/block_mapper.sv
hw/overdrive_ctrl.sv
hw/ram512k_top.sv
verif/ram512k_asserts.sv
verif/ram512k_tb.sv

// File: Bender.yml
package:
  name: ram512k

sources:
  # Package first, then the RTL in dependency order
  - hw/cpc_ram_pkg.sv
  - hw/bank_select_reg.sv
  - hw/bus_cycle_tracker.sv
  - hw/block_mapper.sv
  - hw/overdrive_ctrl.sv
  - hw/ram512k_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/ram512k_asserts.sv
      - verif/ram512k_tb.sv
